// File: filelist.f
rtl/core_pkg.sv
rtl/mem_pkg.sv
rtl/mem_ctrl.sv
rtl/mem_reg.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/mem_subsys_top.sv
sim/mem_subsys_sva.sv
sim/tb_mem_subsys.sv

// File: rtl/core_pkg.sv
////////////////////
// ISA-level types shared by the core
// Data path is XLEN wide and fixed at 32 bits
// Enum encodings are fixed and must match the decoder
////////////////////

package core_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int XLEN      = 32;                  // Data word width
    localparam int HART_ID_W = 2;                   // Up to 4 harts

    typedef logic [XLEN-1:0]      word_t;           // Data word
    typedef logic [4:0]           reg_addr_t;       // GPR index
    typedef logic [HART_ID_W-1:0] hart_id_t;        // Hart id

    ////////////////////
    // Memory operations
    ////////////////////
    typedef enum logic [3:0] {
        MEM_OP_NONE = 4'd0,                         // No access, ALU pass-through
        MEM_OP_LB   = 4'd1,                         // Load byte, sign ext
        MEM_OP_LBU  = 4'd2,                         // Load byte, zero ext
        MEM_OP_LH   = 4'd3,                         // Load half, sign ext
        MEM_OP_LHU  = 4'd4,                         // Load half, zero ext
        MEM_OP_LW   = 4'd5,                         // Load word
        MEM_OP_SB   = 4'd6,                         // Store byte
        MEM_OP_SH   = 4'd7,                         // Store half
        MEM_OP_SW   = 4'd8                          // Store word
    } mem_op_e;

    ////////////////////
    // Exception codes
    ////////////////////
    // Upstream codes all collapse onto EXP_ILLEGAL here
    typedef enum logic [2:0] {
        EXP_NONE           = 3'd0,                  // No exception
        EXP_ILLEGAL        = 3'd1,                  // Raised upstream
        EXP_LOAD_MISALIGN  = 3'd2,                  // Misaligned load
        EXP_STORE_MISALIGN = 3'd3                   // Misaligned store
    } exp_code_e;

endpackage

// File: rtl/data_ram.sv
////////////////////
// Word-wide data RAM
// Read is asynchronous, write on rising edge
// No reset, contents are unknown until written
////////////////////

module data_ram
    import core_pkg::*, mem_pkg::*;
(
    input  logic               clk,
    input  logic [DMEM_AW-1:0] addr,                // Word address
    input  logic               rw,                  // High means write
    input  word_t              wr_data,             // Word to write
    output word_t              rd_data              // Word at addr
);

    word_t mem [DMEM_WORDS];                        // Storage array

    ////////////////////
    // Write port
    ////////////////////
    always_ff @(posedge clk) begin
        if (rw) begin
            mem[addr] <= wr_data;                   // Full word write
        end
    end

    ////////////////////
    // Read port
    ////////////////////
    // Same-cycle read so the stage can merge and extract combinationally
    assign rd_data = mem[addr];

endmodule

// File: rtl/mem_ctrl.sv
////////////////////
// Combinational memory access control
// Expects the RAM to answer in the same cycle
// Misaligned accesses never write and only flag miss_align
////////////////////

module mem_ctrl
    import core_pkg::*, mem_pkg::*;
(
    input  ex_mem_t ex_mem,                         // EX/MEM entry
    input  word_t   rd_data,                        // Word read from RAM
    input  word_t   rd_to_write,                    // Old word for store merge
    output logic    rw,                             // High means write
    output word_t   wr_data,                        // Merged store word
    output word_t   out,                            // Access result
    output logic    load_rdy,                       // Aligned load done
    output logic    miss_align                      // Misaligned access
);

    logic       access;                             // Real memory access
    logic       is_load;
    logic       is_store;
    logic       misaligned;
    logic [1:0] offset;                             // Byte offset in word
    logic [7:0] rd_byte;                            // Selected byte lane
    logic [15:0] rd_half;                           // Selected half lane
    word_t      load_val;                           // Extended load data
    word_t      store_val;                          // Merged store data

    assign offset = ex_mem.out[1:0];

    ////////////////////
    // Decode and alignment
    ////////////////////
    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        case (ex_mem.mem_op)
            MEM_OP_LB, MEM_OP_LBU: is_load = 1'b1;  // Bytes are always aligned
            MEM_OP_LH, MEM_OP_LHU: begin
                is_load    = 1'b1;
                misaligned = offset[0];             // Odd address
            end
            MEM_OP_LW: begin
                is_load    = 1'b1;
                misaligned = |offset;               // Not a multiple of 4
            end
            MEM_OP_SB: is_store = 1'b1;
            MEM_OP_SH: begin
                is_store   = 1'b1;
                misaligned = offset[0];
            end
            MEM_OP_SW: begin
                is_store   = 1'b1;
                misaligned = |offset;
            end
            default: ;                              // MEM_OP_NONE
        endcase
    end

    assign access     = ex_mem.en && (ex_mem.exp_code == EXP_NONE)
                        && (ex_mem.mem_op != MEM_OP_NONE);
    assign miss_align = access && misaligned;
    assign load_rdy   = access && is_load && !misaligned;
    assign rw         = access && is_store && !misaligned;

    ////////////////////
    // Load extraction
    ////////////////////
    assign rd_byte = rd_data[{offset, 3'b000} +: 8];          // Byte lane shift down
    assign rd_half = offset[1] ? rd_data[31:16] : rd_data[15:0];

    always_comb begin
        case (ex_mem.mem_op)
            MEM_OP_LB:  load_val = {{(XLEN-8){rd_byte[7]}}, rd_byte};
            MEM_OP_LBU: load_val = {{(XLEN-8){1'b0}}, rd_byte};
            MEM_OP_LH:  load_val = {{(XLEN-16){rd_half[15]}}, rd_half};
            MEM_OP_LHU: load_val = {{(XLEN-16){1'b0}}, rd_half};
            default:    load_val = rd_data;         // Full word
        endcase
    end

    ////////////////////
    // Store merge
    ////////////////////
    always_comb begin
        store_val = rd_to_write;                    // Keep untouched lanes
        case (ex_mem.mem_op)
            MEM_OP_SB: store_val[{offset, 3'b000} +: 8] = ex_mem.wr_data[7:0];
            MEM_OP_SH: store_val[{offset[1], 4'b0000} +: 16] = ex_mem.wr_data[15:0];
            MEM_OP_SW: store_val = ex_mem.wr_data;  // Whole word replaced
            default: ;
        endcase
    end

    assign wr_data = store_val;                     // Only used when rw high
    assign out     = load_rdy ? load_val : ex_mem.out;

endmodule

// File: rtl/mem_pkg.sv
////////////////////
// Pipeline entries around the MEM stage
// Data RAM is word addressed, out[9:2] selects the word
// gpr_we is active high in both entries
////////////////////

package mem_pkg;

    import core_pkg::*;

    ////////////////////
    // Data RAM size
    ////////////////////
    localparam int DMEM_WORDS = 256;                // Depth in words
    localparam int DMEM_AW    = 8;                  // Word address width

    ////////////////////
    // EX/MEM entry
    ////////////////////
    typedef struct packed {
        logic       en;                             // Entry valid
        mem_op_e    mem_op;                         // Memory operation
        word_t      wr_data;                        // Store data
        word_t      out;                            // ALU result or address
        word_t      pc;                             // Instruction PC
        reg_addr_t  rd_addr;                        // Destination GPR
        logic       gpr_we;                         // GPR write enable
        hart_id_t   hart_id;                        // Owning hart
        exp_code_e  exp_code;                       // Upstream exception
    } ex_mem_t;

    ////////////////////
    // MEM/WB entry
    ////////////////////
    typedef struct packed {
        logic       en;                             // Entry valid
        word_t      out;                            // Load data or ALU result
        word_t      pc;                             // Instruction PC
        reg_addr_t  rd_addr;                        // Destination GPR
        logic       gpr_we;                         // GPR write enable
        hart_id_t   hart_id;                        // Owning hart
        exp_code_e  exp_code;                       // Final exception code
    } mem_wb_t;

endpackage

// File: rtl/mem_reg.sv
////////////////////
// MEM/WB pipeline register
// Flush has priority over stall
// Whole entry clears on reset and on flush
////////////////////

module mem_reg
    import core_pkg::*, mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,                          // Hold entry
    input  logic    flush,                          // Kill entry
    input  ex_mem_t ex_mem,                         // EX/MEM entry
    input  word_t   out,                            // Access result
    input  logic    miss_align,                     // From access control
    input  logic    load_rdy,                       // Aligned load done
    output mem_wb_t mem_wb,                         // MEM/WB entry
    output logic    out_rdy                         // Result came from memory
);

    mem_wb_t   wb_next;                             // Entry to load
    exp_code_e misalign_code;

    // Store ops map to the store code, everything else to load
    assign misalign_code = (ex_mem.mem_op inside {MEM_OP_SB, MEM_OP_SH, MEM_OP_SW})
                           ? EXP_STORE_MISALIGN : EXP_LOAD_MISALIGN;

    always_comb begin
        wb_next.en       = ex_mem.en;
        wb_next.out      = out;
        wb_next.pc       = ex_mem.pc;
        wb_next.rd_addr  = ex_mem.rd_addr;
        wb_next.gpr_we   = ex_mem.gpr_we;
        wb_next.hart_id  = ex_mem.hart_id;
        wb_next.exp_code = ex_mem.exp_code;
        if (miss_align) begin
            wb_next.exp_code = misalign_code;       // Override exception
            wb_next.gpr_we   = 1'b0;                // No writeback on fault
        end
    end

    ////////////////////
    // Register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb  <= '0;
            out_rdy <= 1'b0;
        end else if (flush) begin
            mem_wb  <= '0;                          // Clears en and gpr_we
            out_rdy <= 1'b0;
        end else if (!stall) begin
            mem_wb  <= wb_next;
            out_rdy <= load_rdy;
        end
    end

endmodule

// File: rtl/mem_stage.sv
////////////////////
// Memory access stage
// Stores are suppressed during stall
// fwd_data is combinational and valid in the access cycle
////////////////////

module mem_stage
    import core_pkg::*, mem_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,               // Hold pipeline
    input  logic               flush,               // Kill entry
    input  ex_mem_t            ex_mem,              // EX/MEM entry
    input  word_t              rd_data,             // RAM read word
    input  word_t              rd_to_write,         // Old word for merge
    output logic               rw,                  // RAM write strobe
    output word_t              wr_data,             // RAM write word
    output logic [DMEM_AW-1:0] addr,                // RAM word address
    output word_t              fwd_data,            // Forwarding result
    output mem_wb_t            mem_wb,              // MEM/WB entry
    output logic               out_rdy              // Result from memory
);

    logic  ctrl_rw;                                 // Ungated write strobe
    word_t out;                                     // Access result
    logic  miss_align;
    logic  load_rdy;

    assign addr     = ex_mem.out[DMEM_AW+1:2];      // Drop byte offset
    assign rw       = ctrl_rw && !stall;            // No double write
    assign fwd_data = out;

    mem_ctrl i_mem_ctrl (
        .ex_mem      (ex_mem),
        .rd_data     (rd_data),
        .rd_to_write (rd_to_write),
        .rw          (ctrl_rw),
        .wr_data     (wr_data),
        .out         (out),
        .load_rdy    (load_rdy),
        .miss_align  (miss_align)
    );

    mem_reg i_mem_reg (
        .clk, .rst_n, .stall, .flush, .ex_mem, .out, .miss_align, .load_rdy, .mem_wb, .out_rdy
    );

endmodule

// File: rtl/mem_subsys_top.sv
////////////////////
// Memory stage with its data RAM
// RAM read word doubles as the merge source for stores
////////////////////

module mem_subsys_top
    import core_pkg::*, mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,                          // Hold pipeline
    input  logic    flush,                          // Kill entry
    input  ex_mem_t ex_mem,                         // EX/MEM entry
    output word_t   fwd_data,                       // Forwarding result
    output mem_wb_t mem_wb,                         // MEM/WB entry
    output logic    out_rdy                         // Result from memory
);

    logic [DMEM_AW-1:0] ram_addr;                   // Word address
    logic               ram_rw;                     // Write strobe
    word_t              ram_wr_data;                // Merged write word
    word_t              ram_rd_data;                // Read word

    mem_stage i_mem_stage (
        .clk, .rst_n, .stall, .flush, .ex_mem,
        .rd_data     (ram_rd_data),
        .rd_to_write (ram_rd_data),                 // Same word for merge
        .rw          (ram_rw),
        .wr_data     (ram_wr_data),
        .addr        (ram_addr),
        .fwd_data, .mem_wb, .out_rdy
    );

    data_ram i_data_ram (
        .clk, .addr (ram_addr), .rw (ram_rw), .wr_data (ram_wr_data), .rd_data (ram_rd_data)
    );

endmodule

// File: sim/mem_subsys_sva.sv
////////////////////
// Concurrent checks on the MEM stage register
// Bound into every mem_stage, disabled while in reset
////////////////////

module mem_subsys_sva
    import core_pkg::*, mem_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    stall,
    input logic    flush,
    input logic    rw,                              // Gated write strobe
    input logic    miss_align,
    input mem_wb_t mem_wb
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                               // Failed assertions so far

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> $stable(mem_wb))
        else begin
            $error("mem_wb changed while stalled");
            fail_cnt++;
        end

    a_flush_kill: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !mem_wb.en)                       // Flush wins over stall
        else begin
            $error("mem_wb.en still high after flush");
            fail_cnt++;
        end

    a_no_misaligned_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(rw && miss_align))
        else begin
            $error("RAM write during misaligned access");
            fail_cnt++;
        end

endmodule

bind mem_stage mem_subsys_sva i_sva (
    .clk, .rst_n, .stall, .flush, .rw, .miss_align, .mem_wb
);

// File: sim/tb_mem_subsys.sv
////////////////////
// Directed tests for the MEM stage and its RAM
// Inputs change 1 ns after the rising edge
// RAM has no reset, so every test stores before it loads
////////////////////

module tb_mem_subsys
    import core_pkg::*, mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall;
    logic        flush;
    ex_mem_t     ex_mem;
    word_t       fwd_data;
    mem_wb_t     mem_wb;
    logic        out_rdy;
    word_t       fwd_seen;                          // fwd_data just before the edge
    word_t       shadow [DMEM_WORDS];               // Reference memory
    logic [31:0] rng = 32'h74862022;                // xorshift state

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_subsys_top i_dut (.clk, .rst_n, .stall, .flush, .ex_mem, .fwd_data, .mem_wb, .out_rdy);

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s (%s): expected %h, actual %h", test, what, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic ex_mem_t make_entry(mem_op_e op, word_t addr, word_t data);
        ex_mem_t e;
        word_t   r;
        r          = next_rand();
        e.en       = 1'b1;
        e.mem_op   = op;
        e.wr_data  = data;
        e.out      = addr;
        e.pc       = {r[31:2], 2'b00};
        e.rd_addr  = r[6:2];
        e.gpr_we   = !(op inside {MEM_OP_SB, MEM_OP_SH, MEM_OP_SW});  // Stores write no GPR
        e.hart_id  = r[8:7];
        e.exp_code = EXP_NONE;
        return e;
    endfunction

    function automatic logic is_misaligned(mem_op_e op, word_t addr);
        if (op inside {MEM_OP_LH, MEM_OP_LHU, MEM_OP_SH})
            return addr[0];                         // Halfword on odd byte
        if (op inside {MEM_OP_LW, MEM_OP_SW})
            return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic word_t expected_load(mem_op_e op, word_t addr);
        word_t w;
        w = shadow[addr[9:2]] >> (8 * addr[1:0]);   // Addressed lane to bit 0
        case (op)
            MEM_OP_LB:  return {{24{w[7]}}, w[7:0]};
            MEM_OP_LBU: return {24'h0, w[7:0]};
            MEM_OP_LH:  return {{16{w[15]}}, w[15:0]};
            MEM_OP_LHU: return {16'h0, w[15:0]};
            default:    return w;
        endcase
    endfunction

    function automatic word_t merge_store(mem_op_e op, word_t old, word_t data, logic [1:0] off);
        word_t mask;
        mask = (op == MEM_OP_SB) ? 32'h0000_00FF : (op == MEM_OP_SH) ? 32'h0000_FFFF : '1;
        mask = mask << (8 * off);
        return (old & ~mask) | ((data << (8 * off)) & mask);
    endfunction

    // Present one entry, result is registered at the following edge
    task automatic step(input ex_mem_t e, input logic st, input logic fl);
        ex_mem = e;
        stall  = st;
        flush  = fl;
        @(negedge clk);
        fwd_seen = fwd_data;
        @(posedge clk);
        #1;
    endtask

    task automatic do_access(input string test, input ex_mem_t e);
        string tag;
        logic  bad;
        logic  load;
        word_t exp_out;
        tag     = $sformatf("%s %s@%h", test, e.mem_op.name(), e.out);
        bad     = is_misaligned(e.mem_op, e.out);
        load    = e.mem_op inside {MEM_OP_LB, MEM_OP_LBU, MEM_OP_LH, MEM_OP_LHU, MEM_OP_LW};
        exp_out = (load && !bad) ? expected_load(e.mem_op, e.out) : e.out;
        step(e, 1'b0, 1'b0);
        check_value(tag, "fwd_data", exp_out, fwd_seen);
        check_value(tag, "out", exp_out, mem_wb.out);
        check_value(tag, "pc", e.pc, mem_wb.pc);
        check_value(tag, "rd_addr", e.rd_addr, mem_wb.rd_addr);
        check_value(tag, "hart_id", e.hart_id, mem_wb.hart_id);
        check_value(tag, "en", 1'b1, mem_wb.en);
        check_value(tag, "gpr_we", e.gpr_we && !bad, mem_wb.gpr_we);
        check_value(tag, "out_rdy", load && !bad, out_rdy);
        check_value(tag, "exp_code", !bad ? EXP_NONE :
                    load ? EXP_LOAD_MISALIGN : EXP_STORE_MISALIGN, mem_wb.exp_code);
        if (!bad && !load && e.mem_op != MEM_OP_NONE)
            shadow[e.out[9:2]] = merge_store(e.mem_op, shadow[e.out[9:2]], e.wr_data,
                                             e.out[1:0]);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_reset();
        check_value("reset", "en", 1'b0, mem_wb.en);
        check_value("reset", "gpr_we", 1'b0, mem_wb.gpr_we);
        check_value("reset", "out_rdy", 1'b0, out_rdy);
    endtask

    task automatic test_pass_through();
        repeat (8) do_access("pass_through", make_entry(MEM_OP_NONE, next_rand(), '0));
    endtask

    task automatic test_word_round_trip();
        word_t addrs [16];
        foreach (addrs[i]) begin
            addrs[i] = next_rand() & 32'h3FC;       // Aligned, inside the RAM
            do_access("word_round_trip", make_entry(MEM_OP_SW, addrs[i], next_rand()));
        end
        foreach (addrs[i])
            do_access("word_round_trip", make_entry(MEM_OP_LW, addrs[i], '0));
    endtask

    task automatic test_sub_word();
        word_t base;
        repeat (4) begin
            base = next_rand() & 32'h3FC;
            do_access("sub_word", make_entry(MEM_OP_SW, base, next_rand()));  // Known old word
            for (int off = 0; off < 4; off++) begin
                do_access("sub_word", make_entry(MEM_OP_SB, base + off, next_rand()));
                do_access("sub_word", make_entry(MEM_OP_LB, base + off, '0));
                do_access("sub_word", make_entry(MEM_OP_LBU, base + off, '0));
            end
            for (int off = 0; off < 4; off += 2) begin
                do_access("sub_word", make_entry(MEM_OP_SH, base + off, next_rand()));
                do_access("sub_word", make_entry(MEM_OP_LH, base + off, '0));
                do_access("sub_word", make_entry(MEM_OP_LHU, base + off, '0));
            end
            do_access("sub_word", make_entry(MEM_OP_LW, base, '0));
        end
    endtask

    task automatic test_misalign();
        word_t base;
        base = next_rand() & 32'h3FC;
        do_access("misalign", make_entry(MEM_OP_SW, base, next_rand()));
        for (int off = 1; off < 4; off++) begin
            do_access("misalign", make_entry(MEM_OP_LW, base + off, '0));
            do_access("misalign", make_entry(MEM_OP_SW, base + off, next_rand()));
            if (off != 2) begin
                do_access("misalign", make_entry(MEM_OP_LH, base + off, '0));
                do_access("misalign", make_entry(MEM_OP_SH, base + off, next_rand()));
            end
            do_access("misalign", make_entry(MEM_OP_LW, base, '0));  // Memory unchanged
        end
    endtask

    task automatic test_stall_flush();
        word_t   base;
        mem_wb_t held;
        base = next_rand() & 32'h3FC;
        do_access("stall_flush", make_entry(MEM_OP_SW, base, next_rand()));
        do_access("stall_flush", make_entry(MEM_OP_LW, base, '0));
        held = mem_wb;
        repeat (3) begin
            step(make_entry(MEM_OP_SW, base, ~shadow[base[9:2]]), 1'b1, 1'b0);
            check_value("stall_flush hold", "out", held.out, mem_wb.out);
            check_value("stall_flush hold", "pc", held.pc, mem_wb.pc);
            check_value("stall_flush hold", "en", held.en, mem_wb.en);
            check_value("stall_flush hold", "out_rdy", 1'b1, out_rdy);
        end
        do_access("stall_flush", make_entry(MEM_OP_LW, base, '0));  // Stalled store dropped
        step(make_entry(MEM_OP_LW, base, '0), 1'b1, 1'b1);          // Flush beats stall
        check_value("stall_flush kill", "en", 1'b0, mem_wb.en);
        check_value("stall_flush kill", "gpr_we", 1'b0, mem_wb.gpr_we);
        check_value("stall_flush kill", "out_rdy", 1'b0, out_rdy);
    endtask

    ////////////////////
    // Sequence and watchdog
    ////////////////////
    initial begin
        rst_n  = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        ex_mem = make_entry(MEM_OP_LW, '0, '0);     // Live load held during reset
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_pass_through();
        test_word_round_trip();
        test_sub_word();
        test_misalign();
        test_stall_flush();
        if (i_dut.i_mem_stage.i_sva.fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d concurrent assertions failed", i_dut.i_mem_stage.i_sva.fail_cnt);
            $display("Regression failed");
            $fatal(1);
        end
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);            // 200 cycles per test
        $display("Timeout: the tests did not finish in time");
        $display("Regression failed");
        $fatal(1);
    end

endmodule
